//--- decfail.f
hdl/decfail_pkg.sv
hdl/biterr_sum_36.sv
hdl/biterr_adder_tree.sv
hdl/decfail_cnt.sv
hdl/decfail_cfg_regs.sv
hdl/decfail_stop_ctrl.sv
hdl/decfail_top.sv
tests/tb_clk_gen.sv
tests/decfail_tb.sv

//--- Makefile
# Verilator build and run of the decfail testbench

VERILATOR ?= verilator
TOP       ?= decfail_tb
FLIST     ?= decfail.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/decfail_vectors.txt
# w <addr> <data> | s <load> | r <decfail> <minfail> (72-bit hex) | g <cycles off>
# e <ostop> <ores_ok> <ores_stall> <oiter> <odecfail> <odecfail_est> after last istart
# clean frame stops at iteration 1
s 1
r 000000000000000000 000000000000000000
r 000000000000000000 000000000000000000
s 0
e 1 1 0 1 0 0
# two minimum fails under the default threshold 2
s 1
r 000000000000000001 000000000000000001
r 800000000000000000 800000000000000000
s 0
e 1 1 0 1 0 1
# threshold 1, same rows now fail
w 1 01
s 1
r 000000000000000001 000000000000000001
r 800000000000000000 800000000000000000
s 0
e 0 0 0 1 1 1
w 1 02
# stall, count 4 three times
s 1
r 000000001000000007 000000000000000000
s 0
e 0 0 0 1 1 1
r 000000001000000007 000000000000000000
s 0
e 0 0 0 2 1 1
r 000000001000000007 000000000000000000
s 0
e 1 0 1 3 1 0
# new frame drops the stale history
s 1
r 000000001000000007 000000000000000000
s 0
e 0 0 0 1 1 1
r 000000001000000007 000000000000000000
s 0
e 0 0 0 2 1 1
# iteration limit 3 with changing counts
w 0 03
s 1
r 000000000000000001 000000000000000000
s 0
e 0 0 0 1 1 1
r 000000000000000003 000000000000000000
s 0
e 0 0 0 2 1 1
r 000000000000000007 000000000000000000
s 0
e 1 0 0 3 1 1
w 0 08
# enable gaps inside the row stream
s 1
r 000000000000000001 000000000000000001
g 5
r 000000001000000000 000000000000000000
r 000000000000000100 000000000000000000
g 3
s 0
e 0 0 0 1 1 1
r 000000000000000000 000000000000000000
s 0
e 1 1 0 2 0 0

//--- tests/decfail_tb.sv
`timescale 1ns/100ps

module decfail_tb;

  import decfail_pkg::*;

  localparam int zc_w       = 72;
  localparam int err_w      = 16;
  // 36-bit groups summed in a binary tree
  localparam int tree_d     = $clog2((zc_w + 35) / 36);
  // counter, tree, accumulator, output register
  localparam int lat        = tree_d + 3;
  // minimum spacing from last row to next istart
  localparam int gap        = tree_d + 4;
  localparam int drive_dly  = 10;
  localparam int rst_cycles = 2;
  localparam int cmp_w      = 72;

  logic                  iclk;
  logic                  rst_n;
  logic                  iclkena;
  logic                  iwr;
  logic [cfg_addr_w-1:0] iaddr;
  logic [7:0]            iwdata;
  logic                  istart;
  logic                  iload_iter;
  logic                  ival;
  logic [zc_w-1:0]       irow_decfail;
  logic [zc_w-1:0]       irow_minfail;
  logic                  oval;
  logic                  odecfail;
  logic                  odecfail_est;
  logic                  ostop;
  logic                  ores_ok;
  logic                  ores_stall;
  logic [iter_w-1:0]     oiter;

  // expected oval with one flop per pipeline stage
  logic [lat-1:0]        val_pipe;
  int                    oval_cnt    = 0;
  int                    row_cnt     = 0;
  int                    cycle_cnt   = 0;
  int                    cycle_limit = 10000;
  string                 recs [$];

  // values seen around the last istart
  logic                  seen_df;
  logic                  seen_est;
  logic                  seen_stop;
  logic                  seen_ok;
  logic                  seen_stall;
  logic [iter_w-1:0]     seen_iter;

  tb_clk_gen #(.period(100), .rst_cycles(rst_cycles)) u_clk (
    .iclk  (iclk),
    .rst_n (rst_n)
  );

  decfail_top #(.zc_w(zc_w), .err_w(err_w)) u_dut (
    .iclk         (iclk),
    .rst_n        (rst_n),
    .iclkena      (iclkena),
    .iwr          (iwr),
    .iaddr        (iaddr),
    .iwdata       (iwdata),
    .istart       (istart),
    .iload_iter   (iload_iter),
    .ival         (ival),
    .irow_decfail (irow_decfail),
    .irow_minfail (irow_minfail),
    .oval         (oval),
    .odecfail     (odecfail),
    .odecfail_est (odecfail_est),
    .ostop        (ostop),
    .ores_ok      (ores_ok),
    .ores_stall   (ores_stall),
    .oiter        (oiter)
  );

  // ----------------------------------------------------------
  // compare and abort helpers
  // ----------------------------------------------------------

  task automatic check_val(input string name, input logic [cmp_w-1:0] got,
                           input logic [cmp_w-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // ----------------------------------------------------------
  // drivers start and end at edge plus drive_dly
  // ----------------------------------------------------------

  task automatic step();
    @(posedge iclk);
    #(drive_dly);
  endtask

  task automatic write_reg(input logic [cfg_addr_w-1:0] addr, input logic [7:0] data);
    iwr    = 1'b1;
    iaddr  = addr;
    iwdata = data;
    step();
    iwr    = 1'b0;
  endtask

  task automatic send_row(input logic [zc_w-1:0] df, input logic [zc_w-1:0] mf);
    ival         = 1'b1;
    irow_decfail = df;
    irow_minfail = mf;
    step();
    ival         = 1'b0;
    irow_decfail = '0;
    irow_minfail = '0;
    row_cnt++;
  endtask

  // clock enable low freezes the whole pipeline
  task automatic hold_enable(input int n);
    iclkena = 1'b0;
    repeat (n) step();
    iclkena = 1'b1;
  endtask

  task automatic start_iter(input logic load);
    logic had_rows;
    repeat (gap) step();
    // verdict of the whole iteration is settled now
    seen_df  = odecfail;
    seen_est = odecfail_est;
    check_val("oval count", cmp_w'(oval_cnt), cmp_w'(row_cnt));
    had_rows   = (row_cnt != 0);
    oval_cnt   = 0;
    row_cnt    = 0;
    istart     = 1'b1;
    iload_iter = load;
    step();
    istart     = 1'b0;
    iload_iter = 1'b0;
    // stop decision lands one cycle after istart
    seen_stop  = ostop;
    seen_ok    = ores_ok;
    seen_stall = ores_stall;
    seen_iter  = oiter;
    // no verdict pending means no evaluation
    if (!had_rows) begin
      check_val("ostop", cmp_w'(seen_stop), '0);
    end
    step();
    // ostop lasts a single cycle
    check_val("ostop", cmp_w'(ostop), '0);
  endtask

  task automatic expect_result(input logic [cmp_w-1:0] stop, input logic [cmp_w-1:0] ok,
                               input logic [cmp_w-1:0] stall, input logic [cmp_w-1:0] iter,
                               input logic [cmp_w-1:0] df, input logic [cmp_w-1:0] est);
    check_val("ostop", cmp_w'(seen_stop), stop);
    check_val("ores_ok", cmp_w'(seen_ok), ok);
    check_val("ores_stall", cmp_w'(seen_stall), stall);
    check_val("oiter", cmp_w'(seen_iter), iter);
    check_val("odecfail", cmp_w'(seen_df), df);
    check_val("odecfail_est", cmp_w'(seen_est), est);
  endtask

  // ----------------------------------------------------------
  // monitors
  // ----------------------------------------------------------

  // ival shifted by enabled edges only
  always @(posedge iclk) begin
    if (!rst_n) begin
      val_pipe <= '0;
    end else if (iclkena) begin
      val_pipe <= {val_pipe[lat-2:0], ival};
    end
  end

  // oval timing and count per enabled sample
  always @(negedge iclk) begin
    if (rst_n) begin
      check_val("oval", cmp_w'(oval), cmp_w'(val_pipe[lat-1]));
      if (oval && iclkena) begin
        oval_cnt++;
      end
    end
  end

  always @(posedge iclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    int          fd;
    int          n;
    int          est_cycles;
    string       line;
    logic [7:0]  kind;
    logic [71:0] f0;
    logic [71:0] f1;
    logic [71:0] f2;
    logic [71:0] f3;
    logic [71:0] f4;
    logic [71:0] f5;
    iclkena      = 1'b1;
    iwr          = 1'b0;
    iaddr        = '0;
    iwdata       = '0;
    istart       = 1'b0;
    iload_iter   = 1'b0;
    ival         = 1'b0;
    irow_decfail = '0;
    irow_minfail = '0;
    // load all records and size the timeout
    fd = $fopen("tests/decfail_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("could not open tests/decfail_vectors.txt");
    end
    est_cycles = rst_cycles + 2 + gap;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
        recs.push_back(line);
        n = $sscanf(line, "%c %h", kind, f0);
        case (kind)
          "s": est_cycles += gap + 2;
          "g": est_cycles += int'(f0);
          default: est_cycles += 1;
        endcase
      end
    end
    $fclose(fd);
    cycle_limit = 2 * est_cycles;

    wait (rst_n === 1'b1);
    step();
    // nothing may be pending out of reset
    check_val("oval", cmp_w'(oval), '0);
    check_val("odecfail", cmp_w'(odecfail), '0);
    check_val("odecfail_est", cmp_w'(odecfail_est), '0);
    check_val("ostop", cmp_w'(ostop), '0);
    check_val("ores_ok", cmp_w'(ores_ok), '0);
    check_val("ores_stall", cmp_w'(ores_stall), '0);
    check_val("oiter", cmp_w'(oiter), '0);

    foreach (recs[i]) begin
      n = $sscanf(recs[i], "%c %h %h %h %h %h %h", kind, f0, f1, f2, f3, f4, f5);
      case (kind)
        "w": write_reg(f0[cfg_addr_w-1:0], f1[7:0]);
        "s": start_iter(f0[0]);
        "r": send_row(f0, f1);
        "g": hold_enable(int'(f0));
        "e": expect_result(f0, f1, f2, f3, f4, f5);
        default: abort_run("unknown record type in the vector file");
      endcase
    end
    repeat (gap) step();
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int period     = 100,
  parameter int rst_cycles = 2
) (
  output logic iclk,
  output logic rst_n
);

  // free running clock
  initial begin
    iclk = 1'b0;
    forever #(period / 2) iclk = ~iclk;
  end

  // release away from the edge so sampling stays clean
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge iclk);
    #(period / 4) rst_n = 1'b1;
  end

endmodule

//--- hdl/decfail_top.sv
`timescale 1ns/100ps

module decfail_top #(
  parameter int zc_w  = 72,
  parameter int err_w = 16
) (
  input  logic                               iclk,
  input  logic                               rst_n,
  input  logic                               iclkena,
  // register port
  input  logic                               iwr,
  input  logic [decfail_pkg::cfg_addr_w-1:0] iaddr,
  input  logic [7:0]                         iwdata,
  // decoder control
  input  logic                               istart,
  input  logic                               iload_iter,
  // row stream
  input  logic                               ival,
  input  logic [zc_w-1:0]                    irow_decfail,
  input  logic [zc_w-1:0]                    irow_minfail,
  // per-row verdict
  output logic                               oval,
  output logic                               odecfail,
  output logic                               odecfail_est,
  // per-iteration result
  output logic                               ostop,
  output logic                               ores_ok,
  output logic                               ores_stall,
  output logic [decfail_pkg::iter_w-1:0]     oiter
);

  import decfail_pkg::*;

  // configuration fan-out
  logic [iter_w-1:0] max_iter;
  logic [thr_w-1:0]  min_thr;

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------

  decfail_cfg_regs u_regs (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .iclkena  (iclkena),
    .iwr      (iwr),
    .iaddr    (iaddr),
    .iwdata   (iwdata),
    .max_iter (max_iter),
    .min_thr  (min_thr)
  );

  // ----------------------------------------------------------
  // check counter, tree_d+3 ticks ival to oval
  // ----------------------------------------------------------

  decfail_cnt #(.zc_w(zc_w), .err_w(err_w)) u_cnt (
    .iclk         (iclk),
    .rst_n        (rst_n),
    .iclkena      (iclkena),
    .istart       (istart),
    .iload_iter   (iload_iter),
    .ival         (ival),
    .irow_decfail (irow_decfail),
    .irow_minfail (irow_minfail),
    .min_thr      (min_thr),
    .oval         (oval),
    .odecfail     (odecfail),
    .odecfail_est (odecfail_est)
  );

  // verdict taps straight off the counter outputs
  decfail_stop_ctrl u_stop (
    .iclk        (iclk),
    .rst_n       (rst_n),
    .iclkena     (iclkena),
    .istart      (istart),
    .iload_iter  (iload_iter),
    .oval_cnt    (oval),
    .decfail     (odecfail),
    .decfail_est (odecfail_est),
    .max_iter    (max_iter),
    .ostop       (ostop),
    .ores_ok     (ores_ok),
    .ores_stall  (ores_stall),
    .oiter       (oiter)
  );

endmodule

//--- hdl/decfail_stop_ctrl.sv
`timescale 1ns/100ps

module decfail_stop_ctrl (
  input  logic                           iclk,
  input  logic                           rst_n,
  input  logic                           iclkena,
  input  logic                           istart,
  input  logic                           iload_iter,
  input  logic                           oval_cnt,
  input  logic                           decfail,
  input  logic                           decfail_est,
  input  logic [decfail_pkg::iter_w-1:0] max_iter,
  output logic                           ostop,
  output logic                           ores_ok,
  output logic                           ores_stall,
  output logic [decfail_pkg::iter_w-1:0] oiter
);

  import decfail_pkg::*;

  // number of the running iteration
  logic [iter_w-1:0] iter;
  // a verdict waits for evaluation
  logic              pend;
  logic              df_lat;
  logic              est_lat;
  // evaluation strobe
  logic              eval;
  logic              ok_now;
  logic              stall_now;

  assign eval      = istart && pend;
  assign ok_now    = !df_lat;
  assign stall_now = df_lat && !est_lat;

  // ----------------------------------------------------------
  // iteration count and verdict latch
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      iter    <= '0;
      pend    <= 1'b0;
      df_lat  <= 1'b0;
      est_lat <= 1'b0;
    end else if (iclkena) begin
      if (istart) begin
        iter <= iload_iter ? iter_w'(1) : iter + 1'b1;
      end
      // last oval of the iteration wins
      if (oval_cnt) begin
        df_lat  <= decfail;
        est_lat <= decfail_est;
      end
      if (eval) begin
        pend <= 1'b0;
      end else if (oval_cnt) begin
        pend <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // stop decision, 1 tick after istart
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      ostop      <= 1'b0;
      ores_ok    <= 1'b0;
      ores_stall <= 1'b0;
      oiter      <= '0;
    end else if (iclkena) begin
      // single pulse
      ostop <= 1'b0;
      if (eval) begin
        ores_ok    <= ok_now;
        ores_stall <= stall_now;
        // report the iteration that just ended
        oiter      <= iter;
        ostop      <= ok_now || stall_now || (iter == max_iter);
      end
    end
  end

endmodule

//--- hdl/decfail_cfg_regs.sv
`timescale 1ns/100ps

module decfail_cfg_regs (
  input  logic                               iclk,
  input  logic                               rst_n,
  input  logic                               iclkena,
  input  logic                               iwr,
  input  logic [decfail_pkg::cfg_addr_w-1:0] iaddr,
  input  logic [7:0]                         iwdata,
  output logic [decfail_pkg::iter_w-1:0]     max_iter,
  output logic [decfail_pkg::thr_w-1:0]      min_thr
);

  import decfail_pkg::*;

  // qualified write strobe
  logic wr_en;

  assign wr_en = iwr && iclkena;

  // ----------------------------------------------------------
  // write decode
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      max_iter <= max_iter_rst;
      min_thr  <= min_thr_rst;
    end else if (wr_en) begin
      case (iaddr)
        addr_max_iter: begin
          // low bits only, upper data bits dropped
          max_iter <= iwdata[iter_w-1:0];
        end
        addr_min_thr: begin
          min_thr <= thr_w'(iwdata);
        end
        default: begin
          // unmapped address, write lost
        end
      endcase
    end
  end

endmodule

//--- hdl/decfail_cnt.sv
`timescale 1ns/100ps

module decfail_cnt #(
  parameter int zc_w  = 72,
  parameter int err_w = 16
) (
  input  logic                          iclk,
  input  logic                          rst_n,
  input  logic                          iclkena,
  input  logic                          istart,
  input  logic                          iload_iter,
  input  logic                          ival,
  input  logic [zc_w-1:0]               irow_decfail,
  input  logic [zc_w-1:0]               irow_minfail,
  input  logic [decfail_pkg::thr_w-1:0] min_thr,
  output logic                          oval,
  output logic                          odecfail,
  output logic                          odecfail_est
);

  import decfail_pkg::*;

  // groups needed, last one zero padded if zc_w is not a multiple
  localparam int grp_num = (zc_w + grp_w - 1) / grp_w;
  localparam int pad_w   = grp_num * grp_w;
  localparam int tree_d  = $clog2(grp_num);
  localparam int tree_n  = 2**tree_d;

  logic [pad_w-1:0]   df_pad;
  logic [pad_w-1:0]   mf_pad;
  logic [grp_num-1:0] sum_val;
  logic [err_w-1:0]   sum_err  [grp_num];
  logic [err_w-1:0]   adder_in [tree_n];
  logic               adder_val;
  logic [err_w-1:0]   adder_err;
  logic [grp_num-1:0] mf_or;
  logic               mf_val;
  logic               min_fail;
  logic [err_w-1:0]   checks;
  logic               checks_val;
  logic [err_w-1:0]   hist [2];
  logic [1:0]         hist_val;
  logic [err_w-1:0]   thr_ext;
  logic               over_thr;
  logic               hist_same;

  assign df_pad  = pad_w'(irow_decfail);
  assign mf_pad  = pad_w'(irow_minfail);
  assign thr_ext = err_w'(min_thr);

  // ----------------------------------------------------------
  // group popcounts, 1 tick
  // ----------------------------------------------------------

  for (genvar g = 0; g < grp_num; g++) begin : g_sum
    biterr_sum_36 #(.err_w(err_w)) u_sum (
      .iclk    (iclk),
      .rst_n   (rst_n),
      .iclkena (iclkena),
      .ival    (ival),
      .ibiterr (df_pad[g*grp_w +: grp_w]),
      .oval    (sum_val[g]),
      .oerr    (sum_err[g])
    );
  end

  // tree wants a power of two, tie the spare leaves to zero
  for (genvar i = 0; i < tree_n; i++) begin : g_map
    if (i < grp_num) begin : g_used
      assign adder_in[i] = sum_err[i];
    end else begin : g_pad
      assign adder_in[i] = '0;
    end
  end

  // tree_d ticks
  biterr_adder_tree #(.err_w(err_w), .tree_d(tree_d)) u_tree (
    .iclk    (iclk),
    .rst_n   (rst_n),
    .iclkena (iclkena),
    .ival    (sum_val[0]),
    .ierr    (adder_in),
    .oval    (adder_val),
    .oerr    (adder_err)
  );

  // ----------------------------------------------------------
  // minimum-fail wide or, ready 2 ticks after ival
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      for (int i = 0; i < grp_num; i++) begin
        mf_or[i] <= |mf_pad[i*grp_w +: grp_w];
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      mf_val   <= 1'b0;
      min_fail <= 1'b0;
    end else if (iclkena) begin
      mf_val <= ival;
      if (istart) begin
        min_fail <= 1'b0;
      end else if (mf_val) begin
        min_fail <= min_fail | (|mf_or);
      end
    end
  end

  // ----------------------------------------------------------
  // iteration accumulator and history
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      checks_val <= 1'b0;
      checks     <= '0;
      hist_val   <= '0;
    end else if (iclkena) begin
      checks_val <= adder_val;
      if (istart) begin
        checks <= '0;
        // new frame drops the history, else shift it in
        hist_val <= iload_iter ? 2'b00 : {hist_val[0], 1'b1};
      end else if (adder_val) begin
        checks <= checks + adder_err;
      end
    end
  end

  // history counts, meaningful only under hist_val
  always_ff @(posedge iclk) begin
    if (iclkena && istart) begin
      if (iload_iter) begin
        hist[0] <= '0;
        hist[1] <= '0;
      end else begin
        hist[0] <= checks;
        hist[1] <= hist[0];
      end
    end
  end

  // ----------------------------------------------------------
  // decisions, output register
  // ----------------------------------------------------------

  assign over_thr  = checks > thr_ext;
  assign hist_same = (checks == hist[0]) && (hist[0] == hist[1]);

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      oval         <= 1'b0;
      odecfail     <= 1'b0;
      odecfail_est <= 1'b0;
    end else if (iclkena) begin
      oval <= checks_val;
      // verdicts hold between pulses
      if (checks_val) begin
        odecfail <= min_fail ? over_thr : (checks != '0);
        if (hist_val == 2'b11) begin
          // three equal counts in a row means no progress
          odecfail_est <= (min_fail && over_thr) || !hist_same;
        end else begin
          odecfail_est <= min_fail || (checks != '0);
        end
      end
    end
  end

endmodule

//--- hdl/biterr_adder_tree.sv
`timescale 1ns/100ps

module biterr_adder_tree #(
  parameter int err_w  = 16,
  parameter int tree_d = 1
) (
  input  logic             iclk,
  input  logic             rst_n,
  input  logic             iclkena,
  input  logic             ival,
  input  logic [err_w-1:0] ierr [2**tree_d],
  output logic             oval,
  output logic [err_w-1:0] oerr
);

  // ----------------------------------------------------------
  // one generate level per tree stage
  // level 0 is the raw input, level tree_d the single sum
  // ----------------------------------------------------------

  for (genvar l = 0; l <= tree_d; l++) begin : g_lvl
    // partial sums of this level
    logic [err_w-1:0] lvl_sum [2**(tree_d-l)];
    // valid flag that travels with the level
    logic             lvl_val;

    if (l == 0) begin : g_in
      assign lvl_sum = ierr;
      assign lvl_val = ival;
    end else begin : g_add
      // valid shift stage, cleared on reset
      always_ff @(posedge iclk) begin
        if (!rst_n) begin
          lvl_val <= 1'b0;
        end else if (iclkena) begin
          lvl_val <= g_lvl[l-1].lvl_val;
        end
      end

      // pairwise add of the level below
      always_ff @(posedge iclk) begin
        if (iclkena) begin
          for (int i = 0; i < 2**(tree_d-l); i++) begin
            lvl_sum[i] <= g_lvl[l-1].lvl_sum[2*i] + g_lvl[l-1].lvl_sum[2*i+1];
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // tree root
  // tree_d of 0 gives a plain pass-through
  // ----------------------------------------------------------

  assign oval = g_lvl[tree_d].lvl_val;
  assign oerr = g_lvl[tree_d].lvl_sum[0];

endmodule

//--- hdl/biterr_sum_36.sv
`timescale 1ns/100ps

module biterr_sum_36 #(
  parameter int err_w = 16
) (
  input  logic                           iclk,
  input  logic                           rst_n,
  input  logic                           iclkena,
  input  logic                           ival,
  input  logic [decfail_pkg::grp_w-1:0]  ibiterr,
  output logic                           oval,
  output logic [err_w-1:0]               oerr
);

  import decfail_pkg::*;

  // combinational popcount of the group
  logic [err_w-1:0] ones;

  // ----------------------------------------------------------
  // bit count
  // ----------------------------------------------------------

  always_comb begin
    ones = '0;
    // 36 single-bit adds, synthesis folds into a compressor
    for (int i = 0; i < grp_w; i++) begin
      ones = ones + err_w'(ibiterr[i]);
    end
  end

  // ----------------------------------------------------------
  // output register, 1 tick
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= ival;
    end
  end

  // count is payload only
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      oerr <= ones;
    end
  end

endmodule

//--- hdl/decfail_pkg.sv
package decfail_pkg;

  // ----------------------------------------------------------
  // datapath widths
  // ----------------------------------------------------------

  // one popcount group of the row vector
  localparam int grp_w = 36;
  // iteration numbers, max_iter register
  localparam int iter_w = 6;
  // minimum-fail threshold register
  localparam int thr_w = 8;

  // ----------------------------------------------------------
  // register map
  // ----------------------------------------------------------

  localparam int cfg_addr_w = 2;

  localparam logic [cfg_addr_w-1:0] addr_max_iter = 2'd0;
  localparam logic [cfg_addr_w-1:0] addr_min_thr  = 2'd1;

  // register defaults after reset
  localparam logic [iter_w-1:0] max_iter_rst = 6'd8;
  // weak-node threshold
  localparam logic [thr_w-1:0]  min_thr_rst  = 8'd2;

endpackage
